// File: hdl/fb_pkg.sv
//////////////////////////////////////////////////////////////////////
// framebuffer shared definitions
// raster geometry, memory word layout, colour format and the small
// helpers used by both the fetch side and the output side
//////////////////////////////////////////////////////////////////////
`default_nettype none

package fb_pkg;

    // 720p raster, visible part and full count with blanking
    localparam logic [10:0] H_ACTIVE = 11'd1280;
    localparam logic [9:0]  V_ACTIVE = 10'd720;
    localparam logic [10:0] H_TOTAL  = 11'd1650;
    localparam logic [9:0]  V_TOTAL  = 10'd750;

    // stored pixel is RGB666
    localparam int COLOR_BITS = 18;
    localparam int CH_BITS    = COLOR_BITS / 3;

    // one memory word carries four pixels in 32-bit slots
    localparam int PIX_SLOT     = 32;
    localparam int PIX_PER_WORD = 4;
    localparam int WORD_BITS    = 128;
    localparam int ADDR_BITS    = 20;

    // line pitch in pixels, independent of fb_width
    localparam logic [ADDR_BITS-1:0] FB_MAX_WIDTH = 20'd640;

    // reads start this many cycles ahead of the display window
    localparam logic [10:0] PREFETCH_DELAY = 11'd40;

    localparam int LINE_STORE_DEPTH = 16;
    localparam int LS_ADDR_BITS     = $clog2(LINE_STORE_DEPTH);

    localparam logic [23:0] BORDER_RGB = 24'h202020;

    // widen each channel to 8 bits, low bits zero
    function automatic logic [23:0] to_rgb888(input logic [COLOR_BITS-1:0] p);
        return {p[3*CH_BITS-1:2*CH_BITS], (8-CH_BITS)'(0),
                p[2*CH_BITS-1:CH_BITS],   (8-CH_BITS)'(0),
                p[CH_BITS-1:0],           (8-CH_BITS)'(0)};
    endfunction

    // first column of the centred display window
    function automatic logic [10:0] win_start(input logic [10:0] disp_width);
        return (H_ACTIVE - disp_width) >> 1;
    endfunction

    // one column past the window, sum needs the extra bit
    function automatic logic [10:0] win_end(input logic [10:0] disp_width);
        logic [11:0] sum;
        sum = {1'b0, H_ACTIVE} + {1'b0, disp_width};
        return sum[11:1];
    endfunction

    // error accumulator step, msb of the result flags a source advance
    function automatic logic [11:0] acc_step(input logic [10:0] acc,
                                             input logic [10:0] add,
                                             input logic [10:0] diff);
        if (acc >= diff)
            return {1'b1, acc - diff};
        return {1'b0, acc + add};
    endfunction

endpackage

`default_nettype wire

// File: hdl/video_timing.sv
//////////////////////////////////////////////////////////////////////
// video timing
// free-running 1650 x 750 raster counters with a line start flag
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module video_timing
    import fb_pkg::*;
(
    input  wire logic        clk_x1,
    input  wire logic        reset,
    output logic      [10:0] cx,
    output logic      [9:0]  cy,
    output logic             line_start
);

    // column wraps every line, row steps on the wrap
    always_ff @(posedge clk_x1 or posedge reset) begin
        if (reset) begin
            cx <= '0;
            cy <= '0;
        end else if (cx == H_TOTAL - 11'd1) begin
            cx <= '0;
            if (cy == V_TOTAL - 10'd1)
                cy <= '0;
            else
                cy <= cy + 10'd1;
        end else begin
            cx <= cx + 11'd1;
        end
    end

    // first column of every line
    assign line_start = (cx == 11'd0);

endmodule

`default_nettype wire

// File: hdl/pixel_packer.sv
//////////////////////////////////////////////////////////////////////
// pixel packer
// gathers four input pixels into one memory word and raises a
// write request with the word address of the group
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pixel_packer
    import fb_pkg::*;
(
    input  wire logic                  clk_x1,
    input  wire logic                  reset,
    input  wire logic                  pix_valid,
    input  wire logic [COLOR_BITS-1:0] pix_data,
    input  wire logic                  frame_start,
    input  wire logic [10:0]           fb_width,
    input  wire logic                  wr_ready,
    output logic                       pix_ready,
    output logic                       wr_valid,
    output logic      [ADDR_BITS-1:0]  wr_addr,
    output logic      [WORD_BITS-1:0]  wr_data
);

    localparam int PAD_BITS = PIX_SLOT - COLOR_BITS;

    logic [10:0]           wr_x;
    logic [9:0]            wr_y;
    logic [COLOR_BITS-1:0] stage [3];
    logic                  pix_xfer;
    logic                  word_done;

    // stall only the pixel that would complete a second word
    assign pix_ready = !(wr_valid && wr_x[1:0] == 2'd3);
    assign pix_xfer  = pix_valid && pix_ready;
    assign word_done = pix_xfer && wr_x[1:0] == 2'd3;

    ////////////////////////////////////////////////////////////////////
    // write position and request flag

    always_ff @(posedge clk_x1 or posedge reset) begin
        if (reset) begin
            wr_x     <= '0;
            wr_y     <= '0;
            wr_valid <= 1'b0;
        end else begin
            // request held until the arbiter takes it
            if (word_done)
                wr_valid <= 1'b1;
            else if (wr_ready)
                wr_valid <= 1'b0;

            if (frame_start) begin
                wr_x <= '0;
                wr_y <= '0;
            end else if (pix_xfer) begin
                // column wraps at fb_width into the next row
                if (wr_x + 11'd1 >= fb_width) begin
                    wr_x <= '0;
                    wr_y <= wr_y + 10'd1;
                end else begin
                    wr_x <= wr_x + 11'd1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // staging pixels and the packed word

    always_ff @(posedge clk_x1) begin
        if (pix_xfer && !word_done)
            stage[wr_x[1:0]] <= pix_data;
        // slot 0 holds the oldest pixel of the group
        if (word_done) begin
            wr_data <= {PAD_BITS'(0), pix_data,
                        PAD_BITS'(0), stage[2],
                        PAD_BITS'(0), stage[1],
                        PAD_BITS'(0), stage[0]};
            wr_addr <= ADDR_BITS'(wr_y) * FB_MAX_WIDTH
                     + ADDR_BITS'({wr_x[10:2], 2'b00});
        end
    end

endmodule

`default_nettype wire

// File: hdl/prefetch_scheduler.sv
//////////////////////////////////////////////////////////////////////
// prefetch scheduler
// mirrors the output scaling ahead of the display window and asks
// for each source word of the current row as the fetch column
// reaches it
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module prefetch_scheduler
    import fb_pkg::*;
(
    input  wire logic                 clk_x1,
    input  wire logic                 reset,
    input  wire logic [10:0]          cx,
    input  wire logic [9:0]           cy,
    input  wire logic [10:0]          fb_width,
    input  wire logic [9:0]           fb_height,
    input  wire logic [10:0]          disp_width,
    input  wire logic                 rd_ready,
    output logic                      rd_valid,
    output logic      [ADDR_BITS-1:0] rd_addr
);

    logic [10:0]          x_start, pf_start, diff_w;
    logic [9:0]           diff_h;
    logic [10:0]          pf_x, pf_xacc, nx;
    logic [9:0]           pf_y, pf_yacc, y_next;
    logic [ADDR_BITS-1:0] pf_line, line_next, fetch_addr;
    logic [11:0]          h_step, v_step;
    logic                 pf_run, start_hit, row_ok, col_hit, fetch;

    assign x_start  = win_start(disp_width);
    // a very wide window would start before the line, so clamp to column 1
    assign pf_start = (x_start > PREFETCH_DELAY) ? x_start - PREFETCH_DELAY : 11'd1;
    assign diff_w   = disp_width - fb_width;
    assign diff_h   = V_ACTIVE - fb_height;

    // vertical step for the line that is about to be fetched
    assign v_step    = acc_step({1'b0, pf_yacc}, {1'b0, fb_height}, {1'b0, diff_h});
    assign y_next    = (cy == 10'd0) ? 10'd0 : pf_y + 10'(v_step[11]);
    assign line_next = (cy == 10'd0) ? '0
                     : (v_step[11] ? pf_line + FB_MAX_WIDTH : pf_line);

    // horizontal step, same rule as the scaler
    assign h_step = acc_step(pf_xacc, fb_width, diff_w);
    assign nx     = pf_x + 11'd1;

    assign start_hit  = (cx == pf_start);
    assign row_ok     = (cy < V_ACTIVE) && (y_next < fb_height);
    // new column on a word boundary and still inside the row
    assign col_hit    = !start_hit && pf_run && h_step[11]
                     && nx < fb_width && nx[1:0] == 2'b00;
    assign fetch      = (start_hit && row_ok) || col_hit;
    assign fetch_addr = start_hit ? line_next : pf_line + ADDR_BITS'(nx);

    always_ff @(posedge clk_x1 or posedge reset) begin
        if (reset) begin
            pf_run   <= 1'b0;
            rd_valid <= 1'b0;
            pf_x     <= '0;
            pf_xacc  <= '0;
            pf_y     <= '0;
            pf_yacc  <= '0;
            pf_line  <= '0;
        end else begin
            // one-entry pending register, drained by the arbiter
            if (fetch)
                rd_valid <= 1'b1;
            else if (rd_ready)
                rd_valid <= 1'b0;

            if (start_hit) begin
                pf_x    <= '0;
                pf_xacc <= '0;
                pf_y    <= y_next;
                pf_yacc <= (cy == 10'd0) ? 10'd0 : v_step[9:0];
                pf_line <= line_next;
                pf_run  <= row_ok;
            end else if (pf_run) begin
                pf_xacc <= h_step[10:0];
                if (h_step[11]) begin
                    pf_x <= nx;
                    // whole row requested
                    if (nx >= fb_width)
                        pf_run <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_x1) begin
        if (fetch)
            rd_addr <= fetch_addr;
    end

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
//////////////////////////////////////////////////////////////////////
// memory arbiter
// one registered command slot in front of the word memory, reads
// take the slot ahead of writes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter
    import fb_pkg::*;
(
    input  wire logic                 clk_x1,
    input  wire logic                 reset,
    input  wire logic                 wr_valid,
    input  wire logic [ADDR_BITS-1:0] wr_addr,
    input  wire logic [WORD_BITS-1:0] wr_data,
    input  wire logic                 rd_valid,
    input  wire logic [ADDR_BITS-1:0] rd_addr,
    input  wire logic                 mem_cmd_ready,
    output logic                      wr_ready,
    output logic                      rd_ready,
    output logic                      mem_cmd_valid,
    output logic                      mem_cmd_write,
    output logic      [ADDR_BITS-1:0] mem_addr,
    output logic      [WORD_BITS-1:0] mem_wdata
);

    logic cmd_accept;
    logic load_rd, load_wr;

    // slot is only refilled once empty so a source never issues twice
    assign load_rd    = !mem_cmd_valid && rd_valid;
    assign load_wr    = !mem_cmd_valid && !rd_valid && wr_valid;
    assign cmd_accept = mem_cmd_valid && mem_cmd_ready;

    // ready goes back to the owner of the accepted command
    assign rd_ready = cmd_accept && !mem_cmd_write;
    assign wr_ready = cmd_accept && mem_cmd_write;

    always_ff @(posedge clk_x1 or posedge reset) begin
        if (reset) begin
            mem_cmd_valid <= 1'b0;
            mem_cmd_write <= 1'b0;
        end else if (load_rd || load_wr) begin
            mem_cmd_valid <= 1'b1;
            mem_cmd_write <= load_wr;
        end else if (cmd_accept) begin
            mem_cmd_valid <= 1'b0;
        end
    end

    // address and data held with the command
    always_ff @(posedge clk_x1) begin
        if (load_rd)
            mem_addr <= rd_addr;
        if (load_wr) begin
            mem_addr  <= wr_addr;
            mem_wdata <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pixel_scaler.sv
//////////////////////////////////////////////////////////////////////
// pixel scaler
// fills the line store from returned words, steps the output error
// accumulators and drives the RGB888 pixel with a grey border
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pixel_scaler
    import fb_pkg::*;
(
    input  wire logic                 clk_x1,
    input  wire logic                 reset,
    input  wire logic [10:0]          cx,
    input  wire logic [9:0]           cy,
    input  wire logic                 line_start,
    input  wire logic [10:0]          fb_width,
    input  wire logic [9:0]           fb_height,
    input  wire logic [10:0]          disp_width,
    input  wire logic                 mem_rdata_valid,
    input  wire logic [WORD_BITS-1:0] mem_rdata,
    output logic      [23:0]          rgb
);

    logic [COLOR_BITS-1:0]   line_store [LINE_STORE_DEPTH];
    logic [LS_ADDR_BITS-1:0] ls_wptr, ls_base;
    logic [10:0]             x_start, x_end, diff_w, ox, xacc;
    logic [9:0]              diff_h, oy, yacc;
    logic [11:0]             h_step, v_step;
    logic                    in_window, line_end;

    ////////////////////////////////////////////////////////////////////
    // line store fill

    // pointer restarts with each line, words arrive in issue order
    assign ls_base = line_start ? '0 : ls_wptr;

    always_ff @(posedge clk_x1 or posedge reset) begin
        if (reset)
            ls_wptr <= '0;
        else if (mem_rdata_valid)
            ls_wptr <= ls_base + LS_ADDR_BITS'(PIX_PER_WORD);
        else if (line_start)
            ls_wptr <= '0;
    end

    always_ff @(posedge clk_x1) begin
        if (mem_rdata_valid) begin
            for (int i = 0; i < PIX_PER_WORD; i++)
                line_store[ls_base + LS_ADDR_BITS'(i)] <= mem_rdata[i*PIX_SLOT +: COLOR_BITS];
        end
    end

    ////////////////////////////////////////////////////////////////////
    // output stepping

    assign x_start = win_start(disp_width);
    assign x_end   = win_end(disp_width);
    assign diff_w  = disp_width - fb_width;
    assign diff_h  = V_ACTIVE - fb_height;
    assign h_step  = acc_step(xacc, fb_width, diff_w);
    assign v_step  = acc_step({1'b0, yacc}, {1'b0, fb_height}, {1'b0, diff_h});

    // last column is in blanking, never inside the window
    assign line_end  = (cx == H_TOTAL - 11'd1);
    assign in_window = cx >= x_start && cx < x_end
                    && cy < V_ACTIVE && oy < fb_height;

    always_ff @(posedge clk_x1 or posedge reset) begin
        if (reset) begin
            ox   <= '0;
            xacc <= '0;
            oy   <= '0;
            yacc <= '0;
            rgb  <= BORDER_RGB;
        end else begin
            // prepare the next line
            if (line_end) begin
                ox   <= '0;
                xacc <= '0;
                if (cy == V_TOTAL - 10'd1) begin
                    oy   <= '0;
                    yacc <= '0;
                end else begin
                    oy   <= oy + 10'(v_step[11]);
                    yacc <= v_step[9:0];
                end
            end

            if (in_window) begin
                xacc <= h_step[10:0];
                // source column advances after this pixel
                if (h_step[11])
                    ox <= ox + 11'd1;
                rgb <= to_rgb888(line_store[ox[LS_ADDR_BITS-1:0]]);
            end else begin
                rgb <= BORDER_RGB;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/framebuffer_top.sv
//////////////////////////////////////////////////////////////////////
// framebuffer top level
// pixel stream in, word memory port out, upscaled 720p RGB888 out
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module framebuffer_top
    import fb_pkg::*;
(
    input  wire logic                  clk_x1,
    input  wire logic                  reset,
    // pixel input
    input  wire logic                  pix_valid,
    output logic                       pix_ready,
    input  wire logic [COLOR_BITS-1:0] pix_data,
    input  wire logic                  frame_start,
    input  wire logic [10:0]           fb_width,
    input  wire logic [9:0]            fb_height,
    input  wire logic [10:0]           disp_width,
    // word memory
    output logic                       mem_cmd_valid,
    input  wire logic                  mem_cmd_ready,
    output logic                       mem_cmd_write,
    output logic      [ADDR_BITS-1:0]  mem_addr,
    output logic      [WORD_BITS-1:0]  mem_wdata,
    input  wire logic                  mem_rdata_valid,
    input  wire logic [WORD_BITS-1:0]  mem_rdata,
    // video out
    output logic      [23:0]           rgb,
    output logic      [10:0]           cx,
    output logic      [9:0]            cy
);

    logic                 line_start;
    logic                 wr_valid, wr_ready;
    logic [ADDR_BITS-1:0] wr_addr;
    logic [WORD_BITS-1:0] wr_data;
    logic                 rd_valid, rd_ready;
    logic [ADDR_BITS-1:0] rd_addr;

    video_timing u_timing (
        .clk_x1     (clk_x1),
        .reset      (reset),
        .cx         (cx),
        .cy         (cy),
        .line_start (line_start)
    );

    // write side
    pixel_packer u_packer (
        .clk_x1      (clk_x1),
        .reset       (reset),
        .pix_valid   (pix_valid),
        .pix_data    (pix_data),
        .frame_start (frame_start),
        .fb_width    (fb_width),
        .wr_ready    (wr_ready),
        .pix_ready   (pix_ready),
        .wr_valid    (wr_valid),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    // read side runs ahead of the raster
    prefetch_scheduler u_prefetch (
        .clk_x1     (clk_x1),
        .reset      (reset),
        .cx         (cx),
        .cy         (cy),
        .fb_width   (fb_width),
        .fb_height  (fb_height),
        .disp_width (disp_width),
        .rd_ready   (rd_ready),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr)
    );

    mem_arbiter u_arbiter (
        .clk_x1        (clk_x1),
        .reset         (reset),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .mem_cmd_ready (mem_cmd_ready),
        .wr_ready      (wr_ready),
        .rd_ready      (rd_ready),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_write (mem_cmd_write),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata)
    );

    pixel_scaler u_scaler (
        .clk_x1          (clk_x1),
        .reset           (reset),
        .cx              (cx),
        .cy              (cy),
        .line_start      (line_start),
        .fb_width        (fb_width),
        .fb_height       (fb_height),
        .disp_width      (disp_width),
        .mem_rdata_valid (mem_rdata_valid),
        .mem_rdata       (mem_rdata),
        .rgb             (rgb)
    );

endmodule

`default_nettype wire

// File: test/fb_assert.sv
//////////////////////////////////////////////////////////////////////
// memory port assertions
// command stability under back-pressure and idle port in reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module fb_assert
    import fb_pkg::*;
(
    input wire logic                 clk_x1,
    input wire logic                 reset,
    input wire logic                 mem_cmd_valid,
    input wire logic                 mem_cmd_ready,
    input wire logic                 mem_cmd_write,
    input wire logic [ADDR_BITS-1:0] mem_addr,
    input wire logic [WORD_BITS-1:0] mem_wdata
);

    // a stalled command keeps its fields
    cmd_held: assert property (@(posedge clk_x1) disable iff (reset)
        mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd_write)
            && $stable(mem_addr) && $stable(mem_wdata))
        else $error("memory command changed before it was accepted");

    // no command while reset is applied
    idle_in_reset: assert property (@(posedge clk_x1) reset |-> !mem_cmd_valid)
        else $error("memory command raised during reset");

endmodule

bind mem_arbiter fb_assert u_assert (
    .clk_x1        (clk_x1),
    .reset         (reset),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd_write (mem_cmd_write),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata)
);

`default_nettype wire

// File: test/tb_framebuffer.sv
//////////////////////////////////////////////////////////////////////
// framebuffer testbench
// drives the pixel input, models the word memory with a fixed read
// latency and checks packing, arbitration and the upscaled output
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_framebuffer
    import fb_pkg::*;
;

    localparam int     MEM_LATENCY = 20;
    localparam int     MEM_WORDS   = 4096;
    // three full frames of 100 ns cycles plus some slack
    localparam longint WATCHDOG_NS = 3 * 1650 * 750 * 100 + 100000;

    logic                  clk_x1, reset;
    logic                  pix_valid, pix_ready, frame_start;
    logic [COLOR_BITS-1:0] pix_data;
    logic [10:0]           fb_width, disp_width, cx;
    logic [9:0]            fb_height, cy;
    logic                  mem_cmd_valid, mem_cmd_ready, mem_cmd_write, mem_rdata_valid;
    logic [ADDR_BITS-1:0]  mem_addr;
    logic [WORD_BITS-1:0]  mem_wdata, mem_rdata;
    logic [23:0]           rgb;

    // memory model state and command log
    logic [WORD_BITS-1:0]  mem [MEM_WORDS];
    logic                  log_write [$];
    logic [ADDR_BITS-1:0]  log_addr [$];
    logic [WORD_BITS-1:0]  log_data [$];
    int                    due_q [$];
    logic [ADDR_BITS-1:0]  raddr_q [$];
    int                    cycle, n_writes, throttle_count;

    logic [31:0]           lcg_state;
    logic [COLOR_BITS-1:0] pix_hist [64];
    int                    errors, checks, tests;

    framebuffer_top u_dut (.*);

    initial begin
        clk_x1 = 1'b0;
        forever #50 clk_x1 = ~clk_x1;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not complete within three frames");
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // word memory, one command per cycle, reads return after a fixed delay

    initial begin
        mem_rdata_valid = 1'b0;
        mem_rdata       = '0;
        cycle           = 0;
        n_writes        = 0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = {4{32'(i * 4) ^ 32'h5a5a_0000}};
        forever begin
            @(posedge clk_x1);
            cycle++;
            if (mem_cmd_valid && mem_cmd_ready) begin
                log_write.push_back(mem_cmd_write);
                log_addr.push_back(mem_addr);
                log_data.push_back(mem_wdata);
                if (mem_cmd_write) begin
                    mem[mem_addr[13:2]] = mem_wdata;
                    n_writes++;
                end else begin
                    due_q.push_back(cycle + MEM_LATENCY);
                    raddr_q.push_back(mem_addr);
                end
            end
            #10;
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                mem_rdata_valid = 1'b1;
                mem_rdata       = mem[raddr_q[0][13:2]];
                void'(due_q.pop_front());
                void'(raddr_q.pop_front());
            end else begin
                mem_rdata_valid = 1'b0;
            end
        end
    end

    // counts cycles where an offered pixel is held off
    initial begin
        throttle_count = 0;
        forever begin
            @(posedge clk_x1);
            if (pix_valid && !pix_ready)
                throttle_count++;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [COLOR_BITS-1:0] next_pixel();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[29:12];
    endfunction

    // four pixels zero-extended into 32-bit slots, first pixel lowest
    function automatic logic [WORD_BITS-1:0] expected_word(input int first);
        logic [WORD_BITS-1:0] w;
        w = '0;
        for (int i = 0; i < 4; i++)
            w[i*32 +: 32] = {14'd0, pix_hist[first+i]};
        return w;
    endfunction

    function automatic logic [23:0] expand_colour(input logic [COLOR_BITS-1:0] p);
        return {p[17:12], 2'b00, p[11:6], 2'b00, p[5:0], 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [WORD_BITS-1:0] got,
                               input logic [WORD_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s finished, %0d errors so far", tests, name, errors);
    endtask

    task automatic pulse_frame_start();
        frame_start = 1'b1;
        @(posedge clk_x1);
        #10;
        frame_start = 1'b0;
    endtask

    // offer one pixel until it is taken
    task automatic send_pixel(input logic [COLOR_BITS-1:0] d);
        pix_valid = 1'b1;
        pix_data  = d;
        do begin
            @(posedge clk_x1);
        end while (!pix_ready);
        #10;
        pix_valid = 1'b0;
    endtask

    task automatic wait_writes(input int n);
        int t;
        t = 0;
        while (n_writes < n && t < 2000) begin
            @(posedge clk_x1);
            t++;
        end
        #10;
        if (n_writes < n) begin
            errors++;
            $display("write command %0d never reached the memory", n);
        end
    endtask

    // returns 10 ns after the edge at which the raster was at column x
    task automatic wait_for_column(input int x, input int lo, input int hi);
        do begin
            @(posedge clk_x1);
        end while (!(cx == 11'(x) && cy >= 10'(lo) && cy < 10'(hi)));
        #10;
    endtask

    // index of the n-th write command in the log
    function automatic int write_index(input int n);
        int k;
        k = 0;
        for (int i = 0; i < log_write.size(); i++) begin
            if (log_write[i]) begin
                if (k == n)
                    return i;
                k++;
            end
        end
        return -1;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_reset();
        repeat (2) @(posedge clk_x1);
        #10;
        check_value("mem_cmd_valid in reset", 128'(mem_cmd_valid), 128'd0);
        reset = 1'b0;
        wait_for_column(10, 0, 750);
        check_value("mem_cmd_valid", 128'(mem_cmd_valid), 128'd0);
        check_value("rgb", 128'(rgb), 128'(BORDER_RGB));
        report_test("reset");
    endtask

    task automatic test_write_packing();
        pulse_frame_start();
        for (int i = 0; i < 8; i++) begin
            pix_hist[i] = next_pixel();
            send_pixel(pix_hist[i]);
        end
        wait_writes(2);
        repeat (20) @(posedge clk_x1);
        #10;
        check_value("write count", 128'(n_writes), 128'd2);
        check_value("mem_addr", 128'(log_addr[write_index(0)]), 128'd0);
        check_value("mem_wdata", log_data[write_index(0)], expected_word(0));
        check_value("mem_addr", 128'(log_addr[write_index(1)]), 128'd4);
        check_value("mem_wdata", log_data[write_index(1)], expected_word(4));
        report_test("write packing");
    endtask

    task automatic test_wrap_and_stall();
        int held;
        held = throttle_count;
        mem_cmd_ready = 1'b0;
        for (int i = 8; i < 16; i++)
            pix_hist[i] = next_pixel();
        fork
            begin
                for (int i = 8; i < 16; i++)
                    send_pixel(pix_hist[i]);
            end
            begin
                repeat (40) @(posedge clk_x1);
                #10;
                mem_cmd_ready = 1'b1;
            end
        join
        wait_writes(4);
        if (throttle_count == held) begin
            errors++;
            $display("pix_ready never held off the input while the memory stalled");
        end
        check_value("mem_addr", 128'(log_addr[write_index(2)]), 128'(FB_MAX_WIDTH));
        check_value("mem_wdata", log_data[write_index(2)], expected_word(8));
        check_value("mem_addr", 128'(log_addr[write_index(3)]), 128'(FB_MAX_WIDTH + 4));
        check_value("mem_wdata", log_data[write_index(3)], expected_word(12));
        // restart from the top left corner
        pulse_frame_start();
        for (int i = 16; i < 20; i++) begin
            pix_hist[i] = next_pixel();
            send_pixel(pix_hist[i]);
        end
        wait_writes(5);
        check_value("mem_addr", 128'(log_addr[write_index(4)]), 128'd0);
        check_value("mem_wdata", log_data[write_index(4)], expected_word(16));
        report_test("row wrap and stall");
    endtask

    task automatic test_read_precedence();
        int n0, w, reads, pf_col;
        // first prefetch column of a 16 pixel wide centred window
        pf_col = (1280 - 16) / 2 - 40;
        pulse_frame_start();
        // fourth pixel lands on the edge that raises the line's first read
        wait_for_column(pf_col - 4, 1, 700);
        n0 = log_write.size();
        for (int i = 20; i < 24; i++) begin
            pix_hist[i] = next_pixel();
            send_pixel(pix_hist[i]);
        end
        wait_for_column(700, 1, 700);
        w     = -1;
        reads = 0;
        for (int i = n0; i < log_write.size(); i++) begin
            if (log_write[i] && w < 0)
                w = i;
            else if (!log_write[i] && w < 0)
                reads++;
        end
        if (w < 0) begin
            errors++;
            $display("the pending write never reached the memory");
        end else if (reads == 0) begin
            errors++;
            $display("the pending write was accepted ahead of the prefetch read");
        end
        report_test("read precedence");
    endtask

    task automatic test_upscale();
        logic [COLOR_BITS-1:0] img [32];
        logic [23:0]           exp;
        int                    yacc, oy, xacc, ox, n0;
        logic                  in_win;
        n0 = n_writes;
        pulse_frame_start();
        for (int i = 0; i < 32; i++) begin
            img[i] = next_pixel();
            send_pixel(img[i]);
        end
        wait_writes(n0 + 8);
        // vertical source row of display line 200
        yacc = 0;
        oy   = 0;
        for (int l = 1; l <= 200; l++) begin
            if (yacc >= 720 - 4) begin
                yacc = yacc - (720 - 4);
                oy++;
            end else begin
                yacc = yacc + 4;
            end
        end
        wait_for_column(0, 200, 201);
        xacc = 0;
        ox   = 0;
        for (int c = 0; c < 1650; c++) begin
            in_win = c >= 632 && c < 648 && oy < 4;
            exp    = in_win ? expand_colour(img[oy*8 + (ox % 16)]) : BORDER_RGB;
            if (in_win) begin
                if (xacc >= 16 - 8) begin
                    xacc = xacc - 8;
                    ox++;
                end else begin
                    xacc = xacc + 8;
                end
            end
            check_value("rgb", 128'(rgb), 128'(exp));
            // raster has already moved one column on
            check_value("cx", 128'(cx), 128'((c + 1) % 1650));
            check_value("cy", 128'(cy), 128'((c == 1649) ? 201 : 200));
            @(posedge clk_x1);
            #10;
        end
        report_test("upscaled image");
    endtask

    initial begin
        reset         = 1'b1;
        pix_valid     = 1'b0;
        pix_data      = '0;
        frame_start   = 1'b0;
        fb_width      = 11'd8;
        fb_height     = 10'd4;
        disp_width    = 11'd16;
        mem_cmd_ready = 1'b1;
        lcg_state     = 32'd69;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        test_reset();
        test_write_packing();
        test_wrap_and_stall();
        test_read_precedence();
        test_upscale();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/fb_pkg.sv
hdl/video_timing.sv
hdl/pixel_packer.sv
hdl/prefetch_scheduler.sv
hdl/mem_arbiter.sv
hdl/pixel_scaler.sv
hdl/framebuffer_top.sv
test/fb_assert.sv
test/tb_framebuffer.sv

// File: run_sim.sh
#!/bin/sh
# build and run the framebuffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_framebuffer \
    -f filelist.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_framebuffer >> sim.log 2>&1 \
    || echo "Simulation finished: FAIL" >> sim.log

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
exit 0
